/* source/vc_types.sv */
package vc_types;

	// lc3b memory words and cache lines
	typedef logic [15:0]  lc3b_word;
	typedef logic [127:0] lc3b_burst;

	localparam int VC_WAYS        = 4;
	localparam int VC_OFFSET_BITS = 4;
	localparam int VC_TAG_BITS    = $bits(lc3b_word) - VC_OFFSET_BITS;

	typedef logic [VC_TAG_BITS-1:0]     vc_tag;
	typedef logic [$clog2(VC_WAYS)-1:0] vc_way;

	// mux select encodings shared by control and datapath
	localparam logic BUF_FROM_ARRAY = 1'b0;
	localparam logic BUF_FROM_PMEM  = 1'b1;
	localparam logic WAY_HIT        = 1'b0;
	localparam logic WAY_LRU        = 1'b1;
	localparam logic ADDR_WANTED    = 1'b0;
	localparam logic ADDR_WRITEBACK = 1'b1;

	typedef struct packed {
		logic  valid;
		logic  dirty;
		vc_tag tag;
	} vc_meta_t;

	// one L2 miss: wanted line plus the line being evicted
	typedef struct packed {
		lc3b_word  address;
		lc3b_word  victim_address;
		lc3b_burst victim_data;
		logic      victim_valid;
		logic      victim_dirty;
	} vc_req_t;

	typedef struct packed {
		logic load_buffer;
		logic buffer_sel;
		logic load_entry;
		logic way_sel;
		logic addr_sel;
	} vc_ctrl_t;

	typedef struct packed {
		logic hit;
		logic lru_dirty;
	} vc_status_t;

endpackage

/* source/vc_entry_array.sv */
`timescale 1ns/1ps

module vc_entry_array #(
	parameter type payload_t = logic
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           load,
	input  vc_types::vc_way way,
	input  payload_t       data_in,
	output payload_t       data_out [vc_types::VC_WAYS]
);
	import vc_types::*;

	// zero on reset, so metadata comes up with valid cleared
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < VC_WAYS; i++) begin
				data_out[i] <= '0;
			end
		end else if (load) begin
			data_out[way] <= data_in;
		end
	end

endmodule

/* source/vc_lru.sv */
`timescale 1ns/1ps

module vc_lru (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            load,
	input  vc_types::vc_way used_way,
	output vc_types::vc_way lru_way
);
	import vc_types::*;

	// age rank of each way from 0 oldest to VC_WAYS-1 newest
	vc_way rank [VC_WAYS];
	logic [VC_WAYS-1:0] rank_seen;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < VC_WAYS; i++) begin
				rank[i] <= vc_way'(i);
			end
		end else if (load) begin
			for (int i = 0; i < VC_WAYS; i++) begin
				if (vc_way'(i) == used_way) begin
					rank[i] <= vc_way'(VC_WAYS - 1);
				end else if (rank[i] > rank[used_way]) begin
					// ways younger than the used one move down a slot
					rank[i] <= rank[i] - vc_way'(1);
				end
			end
		end
	end

	always_comb begin
		lru_way   = '0;
		rank_seen = '0;
		for (int i = 0; i < VC_WAYS; i++) begin
			if (rank[i] == '0) begin
				lru_way = vc_way'(i);
			end
			rank_seen[rank[i]] = 1'b1;
		end
	end

	// every rank held by exactly one way after any sequence of updates
	rank_permutation: assert property (
		@(posedge clk) disable iff (!rst_n) &rank_seen
	) else $error("vc_lru: age ranks are not a permutation");

endmodule

/* source/vc_tag_match.sv */
`timescale 1ns/1ps

module vc_tag_match (
	input  vc_types::vc_tag    tag,
	input  vc_types::vc_meta_t meta [vc_types::VC_WAYS],
	output logic               hit,
	output vc_types::vc_way    hit_way
);
	import vc_types::*;

	logic [VC_WAYS-1:0] match;

	always_comb begin
		hit_way = '0;
		for (int i = 0; i < VC_WAYS; i++) begin
			// empty ways never match
			match[i] = meta[i].valid && (meta[i].tag == tag);
			// a line lives in one way at most, so or-ing indices encodes it
			if (match[i]) begin
				hit_way = hit_way | vc_way'(i);
			end
		end
	end

	assign hit = |match;

endmodule

/* source/vc_datapath.sv */
`timescale 1ns/1ps

module vc_datapath (
	input  logic                clk,
	input  logic                rst_n,
	input  vc_types::vc_req_t   req,
	input  vc_types::vc_ctrl_t  ctrl,
	input  vc_types::lc3b_burst pmem_rdata,
	output vc_types::vc_status_t status,
	output vc_types::lc3b_burst rdata,
	output vc_types::lc3b_word  pmem_address,
	output vc_types::lc3b_burst pmem_wdata
);
	import vc_types::*;

	vc_tag     req_tag;
	vc_tag     victim_tag;
	lc3b_burst lines [VC_WAYS];
	vc_meta_t  meta [VC_WAYS];
	vc_meta_t  meta_in;
	vc_way     hit_way;
	vc_way     lru_way;
	vc_way     sel_way;
	logic      hit;
	lc3b_burst swap_buffer;

	// address split
	assign req_tag    = req.address[$bits(lc3b_word)-1 -: VC_TAG_BITS];
	assign victim_tag = req.victim_address[$bits(lc3b_word)-1 -: VC_TAG_BITS];

	// working way for buffer load, writeback and store
	assign sel_way = (ctrl.way_sel == WAY_LRU) ? lru_way : hit_way;

	// clean victim is stored with dirty cleared, no victim leaves the way empty
	assign meta_in.valid = req.victim_valid;
	assign meta_in.dirty = req.victim_valid & req.victim_dirty;
	assign meta_in.tag   = victim_tag;

	vc_entry_array #(.payload_t(lc3b_burst)) i_line_array (
		.clk(clk),
		.rst_n(rst_n),
		.load(ctrl.load_entry),
		.way(sel_way),
		.data_in(req.victim_data),
		.data_out(lines)
	);

	vc_entry_array #(.payload_t(vc_meta_t)) i_meta_array (
		.clk(clk),
		.rst_n(rst_n),
		.load(ctrl.load_entry),
		.way(sel_way),
		.data_in(meta_in),
		.data_out(meta)
	);

	vc_lru i_lru (
		.clk(clk),
		.rst_n(rst_n),
		.load(ctrl.load_entry),
		.used_way(sel_way),
		.lru_way(lru_way)
	);

	vc_tag_match i_tag_match (
		.tag(req_tag),
		.meta(meta),
		.hit(hit),
		.hit_way(hit_way)
	);

	// swap buffer, holds the line going up to the L2
	always_ff @(posedge clk) begin
		if (ctrl.load_buffer) begin
			if (ctrl.buffer_sel == BUF_FROM_PMEM) begin
				swap_buffer <= pmem_rdata;
			end else begin
				swap_buffer <= lines[sel_way];
			end
		end
	end

	assign rdata = swap_buffer;

	// fetch uses the wanted line, writeback rebuilds the address from the stored tag
	assign pmem_address = (ctrl.addr_sel == ADDR_WRITEBACK) ?
		{meta[sel_way].tag, {VC_OFFSET_BITS{1'b0}}} :
		{req_tag, {VC_OFFSET_BITS{1'b0}}};
	assign pmem_wdata = lines[sel_way];

	assign status.hit       = hit;
	assign status.lru_dirty = meta[lru_way].valid & meta[lru_way].dirty;

endmodule

/* source/vc_control.sv */
`timescale 1ns/1ps

module vc_control (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 l2_read,
	input  logic                 pmem_resp,
	input  vc_types::vc_status_t status,
	output vc_types::vc_ctrl_t   ctrl,
	output logic                 l2_resp,
	output logic                 pmem_read,
	output logic                 pmem_write
);
	import vc_types::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_SWAP,
		S_WRITEBACK,
		S_FETCH,
		S_STORE
	} state_t;

	state_t state;
	state_t next_state;
	// remembers whether the request hit, the store needs it after status moves on
	logic   is_hit;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			is_hit  <= 1'b0;
			l2_resp <= 1'b0;
		end else begin
			state   <= next_state;
			// one cycle pulse right after the store edge
			l2_resp <= (state == S_STORE);
			if (state == S_IDLE) begin
				is_hit <= status.hit;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: begin
				// l2_read is still high during the response cycle, ignore it then
				if (l2_read && !l2_resp) begin
					if (status.hit) begin
						next_state = S_SWAP;
					end else if (status.lru_dirty) begin
						next_state = S_WRITEBACK;
					end else begin
						next_state = S_FETCH;
					end
				end
			end
			S_SWAP: begin
				next_state = S_STORE;
			end
			S_WRITEBACK: begin
				if (pmem_resp) begin
					next_state = S_FETCH;
				end
			end
			S_FETCH: begin
				if (pmem_resp) begin
					next_state = S_STORE;
				end
			end
			S_STORE: begin
				next_state = S_IDLE;
			end
			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

	always_comb begin
		ctrl            = '0;
		ctrl.buffer_sel = BUF_FROM_ARRAY;
		ctrl.way_sel    = WAY_HIT;
		ctrl.addr_sel   = ADDR_WANTED;
		pmem_read       = 1'b0;
		pmem_write      = 1'b0;
		case (state)
			S_SWAP: begin
				ctrl.load_buffer = 1'b1;
			end
			S_WRITEBACK: begin
				pmem_write    = 1'b1;
				ctrl.way_sel  = WAY_LRU;
				ctrl.addr_sel = ADDR_WRITEBACK;
			end
			S_FETCH: begin
				pmem_read        = 1'b1;
				ctrl.way_sel     = WAY_LRU;
				ctrl.buffer_sel  = BUF_FROM_PMEM;
				ctrl.load_buffer = pmem_resp;
			end
			S_STORE: begin
				ctrl.load_entry = 1'b1;
				ctrl.way_sel    = is_hit ? WAY_HIT : WAY_LRU;
			end
			default: begin
			end
		endcase
	end

	no_read_and_write: assert property (
		@(posedge clk) disable iff (!rst_n) !(pmem_read && pmem_write)
	) else $error("vc_control: pmem_read and pmem_write high together");

	l2_resp_pulse: assert property (
		@(posedge clk) disable iff (!rst_n) l2_resp |=> !l2_resp
	) else $error("vc_control: l2_resp wider than one cycle");

	// memory request level stays put until memory answers
	pmem_level_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		(pmem_read || pmem_write) && !pmem_resp |=> $stable({pmem_read, pmem_write})
	) else $error("vc_control: memory request dropped before pmem_resp");

	l2_resp_in_request: assert property (
		@(posedge clk) disable iff (!rst_n) l2_resp |-> l2_read
	) else $error("vc_control: l2_resp outside an L2 request");

endmodule

/* source/victim_cache.sv */
`timescale 1ns/1ps

module victim_cache (
	input  logic                clk,
	input  logic                rst_n,

	// L2 side
	input  logic                l2_read,
	input  vc_types::vc_req_t   l2_req,
	output logic                l2_resp,
	output vc_types::lc3b_burst l2_rdata,

	// physical memory side
	input  logic                pmem_resp,
	input  vc_types::lc3b_burst pmem_rdata,
	output logic                pmem_read,
	output logic                pmem_write,
	output vc_types::lc3b_word  pmem_address,
	output vc_types::lc3b_burst pmem_wdata
);
	import vc_types::*;

	vc_ctrl_t   ctrl;
	vc_status_t status;

	vc_control i_control (
		.clk(clk),
		.rst_n(rst_n),
		.l2_read(l2_read),
		.pmem_resp(pmem_resp),
		.status(status),
		.ctrl(ctrl),
		.l2_resp(l2_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write)
	);

	vc_datapath i_datapath (
		.clk(clk),
		.rst_n(rst_n),
		.req(l2_req),
		.ctrl(ctrl),
		.pmem_rdata(pmem_rdata),
		.status(status),
		.rdata(l2_rdata),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata)
	);

endmodule

/* dv/pmem_model.sv */
`timescale 1ns/1ps

module pmem_model (
	input  logic                clk,
	input  logic                read,
	input  logic                write,
	input  vc_types::lc3b_word  address,
	input  vc_types::lc3b_burst wdata,
	output logic                resp,
	output vc_types::lc3b_burst rdata,
	output int                  read_count,
	output int                  write_count
);
	import vc_types::*;

	// cycles from a request being seen to the response pulse
	localparam int RESP_CYCLES = 4;
	localparam int NUM_LINES   = 1 << VC_TAG_BITS;

	lc3b_burst mem [NUM_LINES];
	vc_tag     line;

	assign line = address[$bits(lc3b_word)-1 -: VC_TAG_BITS];

	initial begin
		resp        = 1'b0;
		rdata       = '0;
		read_count  = 0;
		write_count = 0;
		// every word of a line holds the line address
		for (int i = 0; i < NUM_LINES; i++) begin
			mem[i] = {8{lc3b_word'(i << VC_OFFSET_BITS)}};
		end
		forever begin
			// request levels are sampled mid-cycle
			@(negedge clk);
			if (read || write) begin
				repeat (RESP_CYCLES - 1) @(negedge clk);
				@(posedge clk);
				#1;
				if (write) begin
					mem[line]   = wdata;
					write_count = write_count + 1;
				end else begin
					rdata      = mem[line];
					read_count = read_count + 1;
				end
				resp = 1'b1;
				@(posedge clk);
				#1;
				resp = 1'b0;
			end
		end
	end

endmodule

/* dv/tb_victim_cache.sv */
`timescale 1ns/1ps

module tb_victim_cache;
	import vc_types::*;

	localparam int NUM_REQUESTS   = 200;
	localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 20;
	localparam int NUM_LINES      = 8;
	localparam int LOC_MEM        = 0;
	localparam int LOC_VC         = 1;
	localparam int LOC_L2         = 2;

	typedef struct packed {
		logic       valid;
		logic       dirty;
		logic [2:0] slot;
		lc3b_burst  data;
	} ref_entry_t;

	logic      clk;
	logic      rst_n;
	logic      l2_read;
	vc_req_t   l2_req;
	logic      l2_resp;
	lc3b_burst l2_rdata;
	logic      pmem_resp;
	lc3b_burst pmem_rdata;
	logic      pmem_read;
	logic      pmem_write;
	lc3b_word  pmem_address;
	lc3b_burst pmem_wdata;
	int        read_count;
	int        write_count;

	// reference model: latest data per line, where each line lives, LRU order oldest first
	lc3b_burst   content [NUM_LINES];
	int          loc [NUM_LINES];
	logic        l2_dirty [NUM_LINES];
	ref_entry_t  lru_q [$];
	logic [31:0] rng;

	logic      started;
	logic      exp_hit;
	logic      exp_wb;
	lc3b_burst exp_rdata;
	lc3b_word  exp_fetch_addr;
	lc3b_word  exp_wb_addr;
	lc3b_burst exp_wb_data;
	int        exp_reads;
	int        exp_writes;
	int        reads_base;
	int        writes_base;
	int        req_cycles = 0;
	int        cycles = 0;
	int        hit_count = 0;
	int        wb_count = 0;
	int        bare_count = 0;

	victim_cache i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.l2_read(l2_read),
		.l2_req(l2_req),
		.l2_resp(l2_resp),
		.l2_rdata(l2_rdata),
		.pmem_resp(pmem_resp),
		.pmem_rdata(pmem_rdata),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata)
	);

	pmem_model i_pmem (
		.clk(clk),
		.read(pmem_read),
		.write(pmem_write),
		.address(pmem_address),
		.wdata(pmem_wdata),
		.resp(pmem_resp),
		.rdata(pmem_rdata),
		.read_count(read_count),
		.write_count(write_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic lc3b_burst random_line();
		lc3b_burst line;
		for (int i = 0; i < 4; i++) begin
			line[32*i +: 32] = next_random();
		end
		return line;
	endfunction

	// eight aligned lines spread over the address space
	function automatic lc3b_word line_address(int slot);
		return lc3b_word'(32'h0420 + slot * 32'h0130);
	endfunction

	task automatic stop_with_failure(string line);
		$display("%s", line);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic report_mismatch(string msg);
		stop_with_failure($sformatf("FAILED at %0t: %s", $time, msg));
	endtask

	// cycles since l2_read was first sampled high
	always @(posedge clk) begin
		if (!rst_n || !l2_read) begin
			req_cycles <= 0;
		end else begin
			req_cycles <= req_cycles + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			stop_with_failure("timeout: the victim cache stopped answering requests");
		end
	end

	quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!started |-> !l2_resp && !pmem_read && !pmem_write)
		else report_mismatch("handshake activity before the first request");

	fetch_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_read |-> !exp_hit && pmem_address == exp_fetch_addr)
		else report_mismatch("unexpected pmem_read or wrong fetch address");

	writeback_target: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_write |-> exp_wb && pmem_address == exp_wb_addr && pmem_wdata == exp_wb_data)
		else report_mismatch("unexpected pmem_write or wrong writeback line");

	response_data: assert property (@(posedge clk) disable iff (!rst_n)
		l2_resp |-> l2_rdata == exp_rdata)
		else report_mismatch("l2_rdata differs from the reference line");

	memory_traffic: assert property (@(posedge clk) disable iff (!rst_n)
		l2_resp |-> read_count - reads_base == exp_reads
			&& write_count - writes_base == exp_writes)
		else report_mismatch("wrong number of memory reads or writes in a request");

	hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
		l2_resp && exp_hit |-> req_cycles == 3)
		else report_mismatch("hit response not three edges after the request");

	task automatic run_request();
		int         w;
		int         v;
		int         p;
		int         held;
		logic       hit;
		logic       has_victim;
		ref_entry_t old;
		ref_entry_t fresh;
		// the L2 never asks for a line it holds
		w = int'(next_random() % 32'd8);
		while (loc[w] == LOC_L2) begin
			w = int'(next_random() % 32'd8);
		end
		p = 0;
		hit = 1'b0;
		for (int i = 0; i < VC_WAYS; i++) begin
			if (lru_q[i].valid && lru_q[i].slot == 3'(w)) begin
				p = i;
				hit = 1'b1;
			end
		end
		held = 0;
		for (int i = 0; i < NUM_LINES; i++) begin
			held = held + ((loc[i] == LOC_L2) ? 1 : 0);
		end
		// a full L2 must evict, an emptier one sometimes has nothing to give
		has_victim = (held >= 3) || (held > 0 && (next_random() & 32'd3) != 0);
		v = 0;
		fresh = '0;
		if (has_victim) begin
			v = int'(next_random() % 32'd8);
			while (loc[v] != LOC_L2) begin
				v = int'(next_random() % 32'd8);
			end
			if ((next_random() & 32'd1) != 0) begin
				content[v] = random_line();
				l2_dirty[v] = 1'b1;
			end
			fresh.valid = 1'b1;
			fresh.dirty = l2_dirty[v];
			fresh.slot  = 3'(v);
			fresh.data  = content[v];
		end
		old = lru_q[p];
		exp_hit        = hit;
		exp_rdata      = content[w];
		exp_fetch_addr = line_address(w);
		exp_wb         = !hit && old.valid && old.dirty;
		exp_wb_addr    = line_address(int'(old.slot));
		exp_wb_data    = old.data;
		exp_reads      = hit ? 0 : 1;
		exp_writes     = exp_wb ? 1 : 0;
		reads_base     = read_count;
		writes_base    = write_count;
		l2_req.address        = line_address(w) | lc3b_word'(next_random() & 32'hf);
		l2_req.victim_address = has_victim ? line_address(v) | lc3b_word'(next_random() & 32'hf)
			: lc3b_word'(next_random());
		l2_req.victim_data    = has_victim ? fresh.data : random_line();
		l2_req.victim_valid   = has_victim;
		l2_req.victim_dirty   = has_victim ? fresh.dirty : (next_random() & 32'd1) != 0;
		l2_read = 1'b1;
		started = 1'b1;
		@(negedge clk);
		while (!l2_resp) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		l2_read = 1'b0;
		// the line moving up keeps its dirty state in the L2
		if (hit) begin
			l2_dirty[w] = old.dirty;
			hit_count++;
		end else begin
			if (old.valid) begin
				loc[old.slot] = LOC_MEM;
			end
			l2_dirty[w] = 1'b0;
		end
		loc[w] = LOC_L2;
		if (has_victim) begin
			loc[v] = LOC_VC;
		end else begin
			bare_count++;
		end
		if (exp_wb) begin
			wb_count++;
		end
		lru_q.delete(p);
		lru_q.push_back(fresh);
	endtask

	initial begin
		rng     = 32'd95;
		rst_n   = 1'b0;
		l2_read = 1'b0;
		l2_req  = '0;
		started = 1'b0;
		exp_hit = 1'b0;
		exp_wb  = 1'b0;
		for (int k = 0; k < NUM_LINES; k++) begin
			content[k]  = {8{line_address(k)}};
			loc[k]      = LOC_MEM;
			l2_dirty[k] = 1'b0;
		end
		for (int i = 0; i < VC_WAYS; i++) begin
			lru_q.push_back('0);
		end
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (NUM_REQUESTS) begin
			@(posedge clk);
			#1;
			run_request();
		end
		@(posedge clk);
		if (hit_count == 0 || wb_count == 0 || bare_count == 0) begin
			stop_with_failure("stimulus never produced a hit, a writeback or a bare request");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

/* project.f */
source/vc_types.sv
source/vc_entry_array.sv
source/vc_lru.sv
source/vc_tag_match.sv
source/vc_datapath.sv
source/vc_control.sv
source/victim_cache.sv
dv/pmem_model.sv
dv/tb_victim_cache.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_victim_cache \
	-f project.f \
	-o sim_victim_cache

./obj_dir/sim_victim_cache > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
